//--- src/tlb_pkg.sv
package tlb_pkg;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;
    localparam int PPN_W       = 20;
    localparam int VPPN_W      = 19;  // va[31:13], one tag per odd/even pair
    localparam int ASID_W      = 10;

    // one half of a paired entry
    typedef struct packed {
        logic             v;
        logic             d;
        logic [1:0]       plv;  // lowest privilege allowed to use the page
        logic [PPN_W-1:0] ppn;
    } tlb_lo_t;

    typedef struct packed {
        logic              e;
        logic              huge;  // 2MB page when set, 4KB otherwise
        logic [VPPN_W-1:0] vppn;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_lo_t           lo0;   // even page
        tlb_lo_t           lo1;   // odd page
    } tlb_entry_t;

    typedef enum logic [1:0] {
        CMD_NONE     = 2'd0,
        CMD_TLBWR    = 2'd1,
        CMD_INV_ALL  = 2'd2,
        CMD_INV_ASID = 2'd3
    } tlb_cmd_e;

    typedef struct packed {
        tlb_cmd_e             op;
        logic [TLB_IDX_W-1:0] index;
        tlb_entry_t           entry;
        logic [ASID_W-1:0]    asid;   // match key for CMD_INV_ASID
    } tlb_cmd_t;

    typedef struct packed {
        logic [VPPN_W:0]   vpn;   // va[31:12]
        logic [ASID_W-1:0] asid;
    } tlb_search_t;

    typedef struct packed {
        logic    found;
        logic    huge;
        tlb_lo_t lo;
    } tlb_hit_t;

    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_TLBR = 3'd1,  // refill, no matching entry
        EXC_PIL  = 3'd2,
        EXC_PIS  = 3'd3,
        EXC_PIF  = 3'd4,
        EXC_PPI  = 3'd5,
        EXC_PME  = 3'd6   // store to clean page
    } xlat_exc_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] va;
        mem_op_e     op;
    } xlat_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pa;
        xlat_exc_e   exc;
    } xlat_rsp_t;

endpackage

//--- src/csr_pkg.sv
package csr_pkg;

    localparam int APB_ADDR_W = 8;

    // register map
    localparam logic [APB_ADDR_W-1:0] CSR_CRMD    = 8'h00;
    localparam logic [APB_ADDR_W-1:0] CSR_ASID    = 8'h04;
    localparam logic [APB_ADDR_W-1:0] CSR_DMW0    = 8'h08;
    localparam logic [APB_ADDR_W-1:0] CSR_DMW1    = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] CSR_TLBIDX  = 8'h10;
    localparam logic [APB_ADDR_W-1:0] CSR_TLBEHI  = 8'h14;
    localparam logic [APB_ADDR_W-1:0] CSR_TLBELO0 = 8'h18;
    localparam logic [APB_ADDR_W-1:0] CSR_TLBELO1 = 8'h1C;
    localparam logic [APB_ADDR_W-1:0] CSR_TLBCMD  = 8'h20;

    localparam int CRMD_DA_BIT     = 0;
    localparam int CRMD_PLV_LSB    = 1;   // plv is 2 bits
    localparam int DMW_PLV0_BIT    = 0;
    localparam int DMW_PLV3_BIT    = 3;
    localparam int DMW_PSEG_LSB    = 25;  // 3-bit segment fields
    localparam int DMW_VSEG_LSB    = 29;
    localparam int TLBIDX_IDX_LSB  = 0;
    localparam int TLBIDX_HUGE_BIT = 24;
    localparam int TLBIDX_NE_BIT   = 31;
    localparam int TLBEHI_VPPN_LSB = 13;
    localparam int TLBELO_V_BIT    = 0;
    localparam int TLBELO_D_BIT    = 1;
    localparam int TLBELO_PLV_LSB  = 2;
    localparam int TLBELO_G_BIT    = 6;
    localparam int TLBELO_PPN_LSB  = 8;
    localparam int TLBCMD_CODE_LSB = 0;   // 2-bit command code

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [31:0]           pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic       plv0_en;
        logic       plv3_en;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic                      da;
        logic [1:0]                plv;
        logic [tlb_pkg::ASID_W-1:0] asid;
        dmw_t                      dmw0;  // checked first
        dmw_t                      dmw1;
    } xlat_cfg_t;

endpackage

//--- src/csr_regs.sv
module csr_regs (
    input  logic               aclk,
    input  logic               rst_n,
    input  csr_pkg::apb_req_t  apb,
    output csr_pkg::apb_rsp_t  apb_out,
    output csr_pkg::xlat_cfg_t cfg,
    output tlb_pkg::tlb_cmd_t  tlb_cmd
);

    logic                         crmd_da;
    logic [1:0]                   crmd_plv;
    logic [tlb_pkg::ASID_W-1:0]   asid_q;
    csr_pkg::dmw_t                dmw0_q;
    csr_pkg::dmw_t                dmw1_q;
    logic [tlb_pkg::TLB_IDX_W-1:0] idx_index;
    logic                         idx_huge;
    logic                         idx_ne;
    logic [tlb_pkg::VPPN_W-1:0]   ehi_vppn;
    tlb_pkg::tlb_lo_t             elo0_q;
    tlb_pkg::tlb_lo_t             elo1_q;
    logic [1:0]                   elo_g;     // g bit of each ELO register

    logic              access;
    logic              wr_en;
    logic              reg_hit;
    logic [31:0]       rdata;
    tlb_pkg::tlb_cmd_e cmd_op;

    function automatic logic [31:0] dmw_to_word(csr_pkg::dmw_t d);
        logic [31:0] w;
        w = '0;
        w[csr_pkg::DMW_PLV0_BIT]      = d.plv0_en;
        w[csr_pkg::DMW_PLV3_BIT]      = d.plv3_en;
        w[csr_pkg::DMW_PSEG_LSB +: 3] = d.pseg;
        w[csr_pkg::DMW_VSEG_LSB +: 3] = d.vseg;
        return w;
    endfunction

    function automatic csr_pkg::dmw_t word_to_dmw(logic [31:0] w);
        csr_pkg::dmw_t d;
        d.plv0_en = w[csr_pkg::DMW_PLV0_BIT];
        d.plv3_en = w[csr_pkg::DMW_PLV3_BIT];
        d.pseg    = w[csr_pkg::DMW_PSEG_LSB +: 3];
        d.vseg    = w[csr_pkg::DMW_VSEG_LSB +: 3];
        return d;
    endfunction

    function automatic logic [31:0] lo_to_word(tlb_pkg::tlb_lo_t lo, logic g);
        logic [31:0] w;
        w = '0;
        w[csr_pkg::TLBELO_V_BIT]      = lo.v;
        w[csr_pkg::TLBELO_D_BIT]      = lo.d;
        w[csr_pkg::TLBELO_PLV_LSB +: 2] = lo.plv;
        w[csr_pkg::TLBELO_G_BIT]      = g;
        w[csr_pkg::TLBELO_PPN_LSB +: tlb_pkg::PPN_W] = lo.ppn;
        return w;
    endfunction

    function automatic tlb_pkg::tlb_lo_t word_to_lo(logic [31:0] w);
        tlb_pkg::tlb_lo_t lo;
        lo.v   = w[csr_pkg::TLBELO_V_BIT];
        lo.d   = w[csr_pkg::TLBELO_D_BIT];
        lo.plv = w[csr_pkg::TLBELO_PLV_LSB +: 2];
        lo.ppn = w[csr_pkg::TLBELO_PPN_LSB +: tlb_pkg::PPN_W];
        return lo;
    endfunction

    assign access = apb.psel && apb.penable;  // single-cycle access phase
    assign wr_en  = access && apb.pwrite;

    always_comb begin
        reg_hit = 1'b1;
        rdata   = '0;
        case (apb.paddr)
            csr_pkg::CSR_CRMD: begin
                rdata[csr_pkg::CRMD_DA_BIT]       = crmd_da;
                rdata[csr_pkg::CRMD_PLV_LSB +: 2] = crmd_plv;
            end
            csr_pkg::CSR_ASID:    rdata[tlb_pkg::ASID_W-1:0] = asid_q;
            csr_pkg::CSR_DMW0:    rdata = dmw_to_word(dmw0_q);
            csr_pkg::CSR_DMW1:    rdata = dmw_to_word(dmw1_q);
            csr_pkg::CSR_TLBIDX: begin
                rdata[csr_pkg::TLBIDX_IDX_LSB +: tlb_pkg::TLB_IDX_W] = idx_index;
                rdata[csr_pkg::TLBIDX_HUGE_BIT] = idx_huge;
                rdata[csr_pkg::TLBIDX_NE_BIT]   = idx_ne;
            end
            csr_pkg::CSR_TLBEHI:  rdata[csr_pkg::TLBEHI_VPPN_LSB +: tlb_pkg::VPPN_W] = ehi_vppn;
            csr_pkg::CSR_TLBELO0: rdata = lo_to_word(elo0_q, elo_g[0]);
            csr_pkg::CSR_TLBELO1: rdata = lo_to_word(elo1_q, elo_g[1]);
            csr_pkg::CSR_TLBCMD:  rdata = '0;  // write-only
            default:              reg_hit = 1'b0;
        endcase
    end

    assign apb_out.prdata  = access ? rdata : '0;
    assign apb_out.pslverr = access && !reg_hit;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_da   <= 1'b1;  // boot in direct-address mode
            crmd_plv  <= 2'd0;
            asid_q    <= '0;
            dmw0_q    <= '0;
            dmw1_q    <= '0;
            idx_index <= '0;
            idx_huge  <= 1'b0;
            idx_ne    <= 1'b0;
            ehi_vppn  <= '0;
            elo0_q    <= '0;
            elo1_q    <= '0;
            elo_g     <= 2'b00;
        end else if (wr_en) begin
            case (apb.paddr)
                csr_pkg::CSR_CRMD: begin
                    crmd_da  <= apb.pwdata[csr_pkg::CRMD_DA_BIT];
                    crmd_plv <= apb.pwdata[csr_pkg::CRMD_PLV_LSB +: 2];
                end
                csr_pkg::CSR_ASID: asid_q <= apb.pwdata[tlb_pkg::ASID_W-1:0];
                csr_pkg::CSR_DMW0: dmw0_q <= word_to_dmw(apb.pwdata);
                csr_pkg::CSR_DMW1: dmw1_q <= word_to_dmw(apb.pwdata);
                csr_pkg::CSR_TLBIDX: begin
                    idx_index <= apb.pwdata[csr_pkg::TLBIDX_IDX_LSB +: tlb_pkg::TLB_IDX_W];
                    idx_huge  <= apb.pwdata[csr_pkg::TLBIDX_HUGE_BIT];
                    idx_ne    <= apb.pwdata[csr_pkg::TLBIDX_NE_BIT];
                end
                csr_pkg::CSR_TLBEHI:
                    ehi_vppn <= apb.pwdata[csr_pkg::TLBEHI_VPPN_LSB +: tlb_pkg::VPPN_W];
                csr_pkg::CSR_TLBELO0: begin
                    elo0_q   <= word_to_lo(apb.pwdata);
                    elo_g[0] <= apb.pwdata[csr_pkg::TLBELO_G_BIT];
                end
                csr_pkg::CSR_TLBELO1: begin
                    elo1_q   <= word_to_lo(apb.pwdata);
                    elo_g[1] <= apb.pwdata[csr_pkg::TLBELO_G_BIT];
                end
                default: ;  // TLBCMD and unmapped offsets store nothing
            endcase
        end
    end

    // command only lives for the access phase of a TLBCMD write
    always_comb begin
        cmd_op = tlb_pkg::CMD_NONE;
        if (wr_en && apb.paddr == csr_pkg::CSR_TLBCMD) begin
            case (apb.pwdata[csr_pkg::TLBCMD_CODE_LSB +: 2])
                2'd1:    cmd_op = tlb_pkg::CMD_TLBWR;
                2'd2:    cmd_op = tlb_pkg::CMD_INV_ALL;
                2'd3:    cmd_op = tlb_pkg::CMD_INV_ASID;
                default: cmd_op = tlb_pkg::CMD_NONE;
            endcase
        end
    end

    assign tlb_cmd.op         = cmd_op;
    assign tlb_cmd.index      = idx_index;
    assign tlb_cmd.asid       = asid_q;
    assign tlb_cmd.entry.e    = !idx_ne;
    assign tlb_cmd.entry.huge = idx_huge;
    assign tlb_cmd.entry.vppn = ehi_vppn;
    assign tlb_cmd.entry.asid = asid_q;
    assign tlb_cmd.entry.g    = &elo_g;  // global only if both halves say so
    assign tlb_cmd.entry.lo0  = elo0_q;
    assign tlb_cmd.entry.lo1  = elo1_q;

    assign cfg.da   = crmd_da;
    assign cfg.plv  = crmd_plv;
    assign cfg.asid = asid_q;
    assign cfg.dmw0 = dmw0_q;
    assign cfg.dmw1 = dmw1_q;

endmodule

//--- src/tlb_array.sv
module tlb_array (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  tlb_pkg::tlb_cmd_t    tlb_cmd,
    input  tlb_pkg::tlb_search_t search,
    output tlb_pkg::tlb_hit_t    hit
);

    logic [tlb_pkg::TLB_ENTRIES-1:0] e_q;  // entry-exists bits, reset to 0
    tlb_pkg::tlb_entry_t             ent_q [tlb_pkg::TLB_ENTRIES];
    logic [tlb_pkg::TLB_ENTRIES-1:0] match;
    tlb_pkg::tlb_entry_t             sel;
    logic                            odd;

    // tag compare, 2MB pages ignore va[21:13]
    function automatic logic vppn_eq(tlb_pkg::tlb_entry_t ent,
                                     logic [tlb_pkg::VPPN_W:0] vpn);
        logic eq;
        if (ent.huge) begin
            eq = ent.vppn[tlb_pkg::VPPN_W-1:9] == vpn[tlb_pkg::VPPN_W:10];
        end else begin
            eq = ent.vppn == vpn[tlb_pkg::VPPN_W:1];
        end
        return eq;
    endfunction

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else begin
            case (tlb_cmd.op)
                tlb_pkg::CMD_TLBWR:   e_q[tlb_cmd.index] <= tlb_cmd.entry.e;
                tlb_pkg::CMD_INV_ALL: e_q <= '0;
                tlb_pkg::CMD_INV_ASID: begin
                    for (int i = 0; i < tlb_pkg::TLB_ENTRIES; i++) begin
                        if (!ent_q[i].g && ent_q[i].asid == tlb_cmd.asid) begin
                            e_q[i] <= 1'b0;  // globals survive
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // entry payload, e is tracked in e_q
    always_ff @(posedge aclk) begin
        if (tlb_cmd.op == tlb_pkg::CMD_TLBWR) begin
            ent_q[tlb_cmd.index] <= tlb_cmd.entry;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_pkg::TLB_ENTRIES; i++) begin
            match[i] = e_q[i] && vppn_eq(ent_q[i], search.vpn)
                       && (ent_q[i].g || ent_q[i].asid == search.asid);
        end
    end

    // walk downwards so the lowest index wins
    always_comb begin
        sel = '0;
        for (int i = tlb_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel = ent_q[i];
            end
        end
    end

    assign odd = sel.huge ? search.vpn[9] : search.vpn[0];  // va[21] or va[12]

    assign hit.found = |match;
    assign hit.huge  = sel.huge;
    assign hit.lo    = odd ? sel.lo1 : sel.lo0;

endmodule

//--- src/addr_translate.sv
module addr_translate (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  tlb_pkg::xlat_req_t   xlat_in,
    input  csr_pkg::xlat_cfg_t   cfg,
    output tlb_pkg::tlb_search_t search,
    input  tlb_pkg::tlb_hit_t    hit,
    output tlb_pkg::xlat_rsp_t   xlat_out
);

    logic                dmw0_hit;
    logic                dmw1_hit;
    logic [31:0]         tlb_pa;
    tlb_pkg::xlat_exc_e  tlb_exc;
    logic [31:0]         pa_d;
    tlb_pkg::xlat_exc_e  exc_d;

    logic                valid_q;
    logic [31:0]         pa_q;
    tlb_pkg::xlat_exc_e  exc_q;

    // only plv 0 and 3 have enable bits
    function automatic logic win_hit(csr_pkg::dmw_t w, logic [1:0] plv, logic [2:0] seg);
        logic en;
        en = (plv == 2'd0 && w.plv0_en) || (plv == 2'd3 && w.plv3_en);
        return en && (w.vseg == seg);
    endfunction

    assign search.vpn  = xlat_in.va[31:12];
    assign search.asid = cfg.asid;

    assign dmw0_hit = win_hit(cfg.dmw0, cfg.plv, xlat_in.va[31:29]);
    assign dmw1_hit = win_hit(cfg.dmw1, cfg.plv, xlat_in.va[31:29]);

    // page frame merged with offset bits of the page size
    assign tlb_pa = hit.huge ? {hit.lo.ppn[tlb_pkg::PPN_W-1:9], xlat_in.va[20:0]}
                             : {hit.lo.ppn, xlat_in.va[11:0]};

    always_comb begin
        if (!hit.found) begin
            tlb_exc = tlb_pkg::EXC_TLBR;
        end else if (!hit.lo.v) begin
            case (xlat_in.op)
                tlb_pkg::OP_LOAD:  tlb_exc = tlb_pkg::EXC_PIL;
                tlb_pkg::OP_STORE: tlb_exc = tlb_pkg::EXC_PIS;
                default:           tlb_exc = tlb_pkg::EXC_PIF;
            endcase
        end else if (cfg.plv > hit.lo.plv) begin
            tlb_exc = tlb_pkg::EXC_PPI;
        end else if (xlat_in.op == tlb_pkg::OP_STORE && !hit.lo.d) begin
            tlb_exc = tlb_pkg::EXC_PME;
        end else begin
            tlb_exc = tlb_pkg::EXC_NONE;
        end
    end

    always_comb begin
        exc_d = tlb_pkg::EXC_NONE;
        if (cfg.da) begin
            pa_d = xlat_in.va;
        end else if (dmw0_hit) begin
            pa_d = {cfg.dmw0.pseg, xlat_in.va[28:0]};
        end else if (dmw1_hit) begin
            pa_d = {cfg.dmw1.pseg, xlat_in.va[28:0]};
        end else begin
            pa_d  = tlb_pa;
            exc_d = tlb_exc;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= xlat_in.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (xlat_in.valid) begin
            pa_q  <= pa_d;
            exc_q <= exc_d;
        end
    end

    assign xlat_out.valid = valid_q;
    assign xlat_out.pa    = pa_q;
    assign xlat_out.exc   = exc_q;

endmodule

//--- src/mmu_top.sv
module mmu_top (
    input  logic               aclk,
    input  logic               rst_n,
    input  csr_pkg::apb_req_t  apb,
    output csr_pkg::apb_rsp_t  apb_out,
    input  tlb_pkg::xlat_req_t xlat_in,
    output tlb_pkg::xlat_rsp_t xlat_out
);

    csr_pkg::xlat_cfg_t   cfg;      // mode, asid and windows
    tlb_pkg::tlb_cmd_t    tlb_cmd;
    tlb_pkg::tlb_search_t search;
    tlb_pkg::tlb_hit_t    hit;

    csr_regs u_csr_regs (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .apb     (apb),
        .apb_out (apb_out),
        .cfg     (cfg),
        .tlb_cmd (tlb_cmd)
    );

    tlb_array u_tlb_array (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .tlb_cmd (tlb_cmd),
        .search  (search),
        .hit     (hit)
    );

    addr_translate u_addr_translate (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .xlat_in  (xlat_in),
        .cfg      (cfg),
        .search   (search),
        .hit      (hit),
        .xlat_out (xlat_out)
    );

endmodule

//--- bench/mmu_tb.sv
module mmu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] SEED       = 32'h2c94_cef5;

    typedef enum logic [1:0] {
        K_WRITE,
        K_READ,
        K_XLAT,
        K_PAIR  // two random direct-mode requests back to back
    } row_kind_e;

    typedef struct packed {
        row_kind_e          kind;
        logic               rnd;        // va drawn at run time, pa equals va
        logic [31:0]        addr;       // apb offset or va
        logic [31:0]        data;       // write data or access kind
        logic [31:0]        exp_rdata;
        logic               exp_err;
        logic [31:0]        exp_pa;
        tlb_pkg::xlat_exc_e exp_exc;
    } row_t;

    logic               aclk;
    logic               rst_n;
    csr_pkg::apb_req_t  apb_req;
    csr_pkg::apb_rsp_t  apb_rsp;
    tlb_pkg::xlat_req_t xlat_req;
    tlb_pkg::xlat_rsp_t xlat_rsp;

    row_t  rows[$];
    string names[$];
    int    errors;
    int    checks;
    logic  table_ready;

    mmu_top UUT (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .apb      (apb_req),
        .apb_out  (apb_rsp),
        .xlat_in  (xlat_req),
        .xlat_out (xlat_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic logic [31:0] lo_word(input logic v, input logic d, input logic [1:0] plv,
                                            input logic g, input logic [19:0] ppn);
        return {4'h0, ppn, 1'b0, g, 2'b00, plv, d, v};
    endfunction

    function automatic logic [31:0] dmw_word(input logic plv0, input logic plv3,
                                             input logic [2:0] pseg, input logic [2:0] vseg);
        return {vseg, 1'b0, pseg, 21'd0, plv3, 2'b00, plv0};
    endfunction

    function automatic void push_row(input string name, input row_kind_e kind, input logic rnd,
                                     input logic [31:0] addr, input logic [31:0] data,
                                     input logic [31:0] rdata, input logic err,
                                     input logic [31:0] pa, input tlb_pkg::xlat_exc_e exc);
        row_t r;
        r.kind      = kind;
        r.rnd       = rnd;
        r.addr      = addr;
        r.data      = data;
        r.exp_rdata = rdata;
        r.exp_err   = err;
        r.exp_pa    = pa;
        r.exp_exc   = exc;
        rows.push_back(r);
        names.push_back(name);
    endfunction

    function automatic void write_row(input string name, input logic [7:0] addr,
                                      input logic [31:0] data, input logic err);
        push_row(name, K_WRITE, 1'b0, {24'd0, addr}, data, 32'd0, err, 32'd0, tlb_pkg::EXC_NONE);
    endfunction

    function automatic void read_row(input string name, input logic [7:0] addr,
                                     input logic [31:0] rdata, input logic err);
        push_row(name, K_READ, 1'b0, {24'd0, addr}, 32'd0, rdata, err, 32'd0, tlb_pkg::EXC_NONE);
    endfunction

    function automatic void xlat_row(input string name, input logic [31:0] va,
                                     input tlb_pkg::mem_op_e op, input logic [31:0] pa,
                                     input tlb_pkg::xlat_exc_e exc);
        push_row(name, K_XLAT, 1'b0, va, {30'd0, op}, 32'd0, 1'b0, pa, exc);
    endfunction

    function automatic void rand_row(input string name);
        push_row(name, K_XLAT, 1'b1, 32'd0, 32'd0, 32'd0, 1'b0, 32'd0, tlb_pkg::EXC_NONE);
    endfunction

    function automatic void pair_row(input string name);
        push_row(name, K_PAIR, 1'b1, 32'd0, 32'd0, 32'd0, 1'b0, 32'd0, tlb_pkg::EXC_NONE);
    endfunction

    task automatic fill_table();
        // register access
        write_row("asid write", csr_pkg::CSR_ASID, 32'hFFFF_FD55, 1'b0);
        read_row("asid read", csr_pkg::CSR_ASID, 32'h0000_0155, 1'b0);
        write_row("dmw0 write", csr_pkg::CSR_DMW0, 32'hFFFF_FFFF, 1'b0);
        read_row("dmw0 read", csr_pkg::CSR_DMW0, 32'hEE00_0009, 1'b0);
        write_row("dmw1 write", csr_pkg::CSR_DMW1, dmw_word(1'b1, 1'b0, 3'd2, 3'd6), 1'b0);
        read_row("dmw1 read", csr_pkg::CSR_DMW1, dmw_word(1'b1, 1'b0, 3'd2, 3'd6), 1'b0);
        write_row("tlbidx write", csr_pkg::CSR_TLBIDX, 32'hFFFF_FFF5, 1'b0);
        read_row("tlbidx read", csr_pkg::CSR_TLBIDX, 32'h8100_0005, 1'b0);
        write_row("tlbehi write", csr_pkg::CSR_TLBEHI, 32'hFFFF_FFFF, 1'b0);
        read_row("tlbehi read", csr_pkg::CSR_TLBEHI, 32'hFFFF_E000, 1'b0);
        write_row("tlbelo0 write", csr_pkg::CSR_TLBELO0, 32'hFFFF_FFFF, 1'b0);
        read_row("tlbelo0 read", csr_pkg::CSR_TLBELO0, 32'h0FFF_FF4F, 1'b0);
        write_row("tlbelo1 write", csr_pkg::CSR_TLBELO1, lo_word(1, 0, 2, 0, 20'h0ABCD), 1'b0);
        read_row("tlbelo1 read", csr_pkg::CSR_TLBELO1, lo_word(1, 0, 2, 0, 20'h0ABCD), 1'b0);
        write_row("crmd write", csr_pkg::CSR_CRMD, 32'hFFFF_FFFF, 1'b0);
        read_row("crmd read", csr_pkg::CSR_CRMD, 32'h0000_0007, 1'b0);
        write_row("crmd restore", csr_pkg::CSR_CRMD, 32'h0000_0001, 1'b0);
        read_row("crmd reread", csr_pkg::CSR_CRMD, 32'h0000_0001, 1'b0);
        read_row("tlbcmd read", csr_pkg::CSR_TLBCMD, 32'd0, 1'b0);
        read_row("unmapped read", 8'h24, 32'd0, 1'b1);
        write_row("unmapped write", 8'h80, 32'hDEAD_BEEF, 1'b1);
        // direct mode, random vas
        rand_row("direct random 0");
        rand_row("direct random 1");
        rand_row("direct random 2");
        pair_row("direct back to back");
        // direct windows, both cover segment 4
        write_row("dmw0 setup", csr_pkg::CSR_DMW0, dmw_word(1'b1, 1'b0, 3'd5, 3'd4), 1'b0);
        write_row("dmw1 setup", csr_pkg::CSR_DMW1, dmw_word(1'b1, 1'b1, 3'd2, 3'd4), 1'b0);
        write_row("crmd plv0", csr_pkg::CSR_CRMD, 32'h0, 1'b0);
        xlat_row("dmw0 priority", 32'h8123_4567, tlb_pkg::OP_LOAD, 32'hA123_4567, tlb_pkg::EXC_NONE);
        write_row("crmd plv3", csr_pkg::CSR_CRMD, 32'h6, 1'b0);
        xlat_row("dmw1 at plv3", 32'h8123_4567, tlb_pkg::OP_LOAD, 32'h4123_4567, tlb_pkg::EXC_NONE);
        write_row("crmd plv1", csr_pkg::CSR_CRMD, 32'h2, 1'b0);
        xlat_row("plv1 no window", 32'h8123_4567, tlb_pkg::OP_LOAD, 32'h0, tlb_pkg::EXC_TLBR);
        write_row("crmd plv0 again", csr_pkg::CSR_CRMD, 32'h0, 1'b0);
        // 4KB entry at index 2, asid 0x011
        write_row("asid 011", csr_pkg::CSR_ASID, 32'h011, 1'b0);
        write_row("ehi 4k", csr_pkg::CSR_TLBEHI, 32'h0040_2000, 1'b0);
        write_row("elo0 4k", csr_pkg::CSR_TLBELO0, lo_word(1, 1, 0, 0, 20'h12345), 1'b0);
        write_row("elo1 4k", csr_pkg::CSR_TLBELO1, lo_word(1, 1, 0, 0, 20'h54321), 1'b0);
        write_row("idx 4k", csr_pkg::CSR_TLBIDX, 32'h0000_0002, 1'b0);
        write_row("tlbwr 4k", csr_pkg::CSR_TLBCMD, 32'h1, 1'b0);
        xlat_row("4k even", 32'h0040_2ABC, tlb_pkg::OP_LOAD, 32'h1234_5ABC, tlb_pkg::EXC_NONE);
        xlat_row("4k odd", 32'h0040_3DEF, tlb_pkg::OP_FETCH, 32'h5432_1DEF, tlb_pkg::EXC_NONE);
        // global 2MB entry at index 7, low ppn bits are ignored
        write_row("ehi 2m", csr_pkg::CSR_TLBEHI, 32'h0140_0000, 1'b0);
        write_row("elo0 2m", csr_pkg::CSR_TLBELO0, lo_word(1, 1, 0, 1, 20'h0AA1F), 1'b0);
        write_row("elo1 2m", csr_pkg::CSR_TLBELO1, lo_word(1, 1, 0, 1, 20'h0CC00), 1'b0);
        write_row("idx 2m", csr_pkg::CSR_TLBIDX, 32'h0100_0007, 1'b0);
        write_row("tlbwr 2m", csr_pkg::CSR_TLBCMD, 32'h1, 1'b0);
        xlat_row("2m even", 32'h0145_6789, tlb_pkg::OP_LOAD, 32'h0AA5_6789, tlb_pkg::EXC_NONE);
        xlat_row("2m odd", 32'h0171_2345, tlb_pkg::OP_STORE, 32'h0CD1_2345, tlb_pkg::EXC_NONE);
        write_row("asid 022", csr_pkg::CSR_ASID, 32'h022, 1'b0);
        xlat_row("asid mismatch", 32'h0040_2ABC, tlb_pkg::OP_LOAD, 32'h0, tlb_pkg::EXC_TLBR);
        xlat_row("global any asid", 32'h0145_6789, tlb_pkg::OP_FETCH, 32'h0AA5_6789,
                 tlb_pkg::EXC_NONE);
        write_row("asid 011 again", csr_pkg::CSR_ASID, 32'h011, 1'b0);
        // index 4, invalid even half and clean odd half
        write_row("ehi exc", csr_pkg::CSR_TLBEHI, 32'h0060_0000, 1'b0);
        write_row("elo0 exc", csr_pkg::CSR_TLBELO0, lo_word(0, 1, 0, 0, 20'h11111), 1'b0);
        write_row("elo1 exc", csr_pkg::CSR_TLBELO1, lo_word(1, 0, 0, 0, 20'h22222), 1'b0);
        write_row("idx exc", csr_pkg::CSR_TLBIDX, 32'h0000_0004, 1'b0);
        write_row("tlbwr exc", csr_pkg::CSR_TLBCMD, 32'h1, 1'b0);
        xlat_row("invalid fetch", 32'h0060_0010, tlb_pkg::OP_FETCH, 32'h0, tlb_pkg::EXC_PIF);
        xlat_row("invalid load", 32'h0060_0010, tlb_pkg::OP_LOAD, 32'h0, tlb_pkg::EXC_PIL);
        xlat_row("invalid store", 32'h0060_0010, tlb_pkg::OP_STORE, 32'h0, tlb_pkg::EXC_PIS);
        xlat_row("clean store", 32'h0060_1234, tlb_pkg::OP_STORE, 32'h0, tlb_pkg::EXC_PME);
        xlat_row("clean load", 32'h0060_1234, tlb_pkg::OP_LOAD, 32'h2222_2234, tlb_pkg::EXC_NONE);
        write_row("crmd plv3 tlb", csr_pkg::CSR_CRMD, 32'h6, 1'b0);
        xlat_row("privilege", 32'h0040_2ABC, tlb_pkg::OP_LOAD, 32'h0, tlb_pkg::EXC_PPI);
        write_row("crmd plv0 tlb", csr_pkg::CSR_CRMD, 32'h0, 1'b0);
        // invalidation
        write_row("inv asid", csr_pkg::CSR_TLBCMD, 32'h3, 1'b0);
        xlat_row("inv asid 4k gone", 32'h0040_2ABC, tlb_pkg::OP_LOAD, 32'h0, tlb_pkg::EXC_TLBR);
        xlat_row("inv asid exc gone", 32'h0060_1234, tlb_pkg::OP_LOAD, 32'h0, tlb_pkg::EXC_TLBR);
        xlat_row("inv asid global kept", 32'h0145_6789, tlb_pkg::OP_LOAD, 32'h0AA5_6789,
                 tlb_pkg::EXC_NONE);
        write_row("inv all", csr_pkg::CSR_TLBCMD, 32'h2, 1'b0);
        xlat_row("inv all global gone", 32'h0171_2345, tlb_pkg::OP_LOAD, 32'h0, tlb_pkg::EXC_TLBR);
    endtask

    // called at a falling edge, returns at a falling edge with the bus idle
    task automatic apb_access(input string name, input row_t r);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = (r.kind == K_WRITE);
        apb_req.paddr   = r.addr[csr_pkg::APB_ADDR_W-1:0];
        apb_req.pwdata  = r.data;
        @(negedge aclk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);  // middle of the low phase
        checks++;
        if (apb_rsp.pslverr !== r.exp_err) begin
            errors++;
            $display("mismatch %s: pslverr expected %0b actual %0b",
                     name, r.exp_err, apb_rsp.pslverr);
        end
        if (r.kind == K_READ && apb_rsp.prdata !== r.exp_rdata) begin
            errors++;
            $display("mismatch %s: prdata expected %h actual %h",
                     name, r.exp_rdata, apb_rsp.prdata);
        end
        @(negedge aclk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic check_rsp(input string name, input logic [31:0] exp_pa,
                             input tlb_pkg::xlat_exc_e exp_exc);
        checks++;
        if (xlat_rsp.valid !== 1'b1) begin
            errors++;
            $display("%s: no valid translation result in the cycle after the request", name);
        end else begin
            if (xlat_rsp.exc !== exp_exc) begin
                errors++;
                $display("mismatch %s: exc expected %s actual %s",
                         name, exp_exc.name(), xlat_rsp.exc.name());
            end
            if (exp_exc == tlb_pkg::EXC_NONE && xlat_rsp.pa !== exp_pa) begin
                errors++;
                $display("mismatch %s: pa expected %h actual %h", name, exp_pa, xlat_rsp.pa);
            end
        end
    endtask

    task automatic translate_once(input string name, input row_t r);
        logic [31:0]      va;
        logic [31:0]      exp_pa;
        tlb_pkg::mem_op_e op;
        va     = r.addr;
        exp_pa = r.exp_pa;
        op     = tlb_pkg::mem_op_e'(r.data[1:0]);
        if (r.rnd) begin
            va     = $urandom;
            exp_pa = va;  // direct mode passes the va through
            op     = tlb_pkg::mem_op_e'(2'($urandom % 3));
        end
        xlat_req.valid = 1'b1;
        xlat_req.va    = va;
        xlat_req.op    = op;
        @(negedge aclk);
        xlat_req.valid = 1'b0;
        check_rsp(name, exp_pa, r.exp_exc);
    endtask

    task automatic translate_pair(input string name);
        logic [31:0] va_a;
        logic [31:0] va_b;
        va_a = $urandom;
        va_b = $urandom;
        xlat_req.valid = 1'b1;
        xlat_req.va    = va_a;
        xlat_req.op    = tlb_pkg::OP_LOAD;
        @(negedge aclk);
        xlat_req.va = va_b;  // second request while the first result is out
        xlat_req.op = tlb_pkg::OP_FETCH;
        check_rsp({name, " first"}, va_a, tlb_pkg::EXC_NONE);
        @(negedge aclk);
        xlat_req.valid = 1'b0;
        check_rsp({name, " second"}, va_b, tlb_pkg::EXC_NONE);
    endtask

    initial begin
        int limit;
        int cycles;
        wait (table_ready === 1'b1);
        limit  = 10 * rows.size() + 20;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        rst_n       = 1'b0;
        apb_req     = '0;
        xlat_req    = '0;
        fill_table();
        table_ready = 1'b1;
        repeat (4) @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);
        for (int i = 0; i < rows.size(); i++) begin
            case (rows[i].kind)
                K_WRITE, K_READ: apb_access(names[i], rows[i]);
                K_XLAT:          translate_once(names[i], rows[i]);
                default:         translate_pair(names[i]);
            endcase
        end
        $display("rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
src/tlb_pkg.sv
src/csr_pkg.sv
src/csr_regs.sv
src/tlb_array.sv
src/addr_translate.sv
src/mmu_top.sv
bench/mmu_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module mmu_tb \
    -f sources.f -o mmu_sim > build.log 2>&1 \
    && ./obj_dir/mmu_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
